// ==== hdl/lora_soc_params.svh ====
// LoRa peripheral subsystem constants: bus widths, slot map, timing and identifiers
`ifndef LORA_SOC_PARAMS_SVH
`define LORA_SOC_PARAMS_SVH

// ====================
// Bus geometry
// ====================
`define LORA_DATA_W          32
`define LORA_ADR_W           8         // Byte address, bit 7 set = no peripheral
`define LORA_SLOT_W          5         // Word slot from adr[6:2]
`define LORA_PIN_W           8
`define LORA_PPS_W           16

// ====================
// Peripheral slot map
// ====================
`define LORA_SLOT_GPIO_OUT   5'd0
`define LORA_SLOT_GPIO_IN    5'd1
`define LORA_SLOT_GPIO_SEL   5'd3
`define LORA_SLOT_TIMER      5'd12
`define LORA_SLOT_WDT        5'd13
`define LORA_SLOT_SYSINFO    5'd15

`define LORA_TICK_DIV        25        // 25 MHz clock down to 1 us
`define LORA_RST_HOLD        32        // Peripheral reset hold in clocks
`define LORA_SOFT_RST_KEY    8'hA5
`define LORA_CHIP_ID         8'h01
`define LORA_VERSION         8'h10
`define LORA_GPIO_DEFAULT    8'h02     // Only radio reset (pin 1) idles high
`define LORA_UNMAPPED_READ   32'hFFFF_FFFF

`endif

// ==== hdl/lora_soc_pkg.sv ====
// Shared bus, register strobe, readback and pin types of the LoRa peripheral subsystem
`default_nettype none

`include "lora_soc_params.svh"

package lora_soc_pkg;

    // ====================
    // Wishbone classic
    // ====================
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`LORA_ADR_W-1:0]  adr;
        logic [`LORA_DATA_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                   ack;
        logic [`LORA_DATA_W-1:0] dat;
    } wb_rsp_t;

    // Input pins, ui_in order
    typedef struct packed {
        logic [2:0] aux_hi;     // Spare inputs 7..5
        logic       pps;        // 1PPS from GNSS
        logic [3:0] aux_lo;     // DIO1, BUSY and spares
    } pin_in_t;

    // Output pins
    typedef struct packed {
        logic [5:0] upper;      // Pins 7..2
        logic       radio_rst_n;
        logic       lower;      // Pin 0
    } pin_out_t;

    // One-cycle write strobes, one per writable slot
    typedef struct packed {
        logic                   gpio_out_we;
        logic                   gpio_sel_we;
        logic                   timer_we;
        logic                   wdt_we;
        logic                   sysinfo_we;
        logic [`LORA_DATA_W-1:0] dat;
    } reg_wr_t;

    // Readback from the peripheral blocks
    typedef struct packed {
        logic [`LORA_DATA_W-1:0] timer_count;
        logic [`LORA_DATA_W-1:0] wdt_remaining;
        logic [`LORA_PIN_W-1:0]  gpio_out;
        logic [`LORA_PIN_W-1:0]  gpio_sel;
        pin_out_t               pins;
        logic [`LORA_DATA_W-1:0] sysinfo;
    } reg_rd_t;

endpackage

`default_nettype wire

// ==== hdl/periph_bus_decode.sv ====
// Wishbone slave with one wait state: slot decode, write strobes and read mux
`default_nettype none

`include "lora_soc_params.svh"

module periph_bus_decode (
    input  wire                       clk,
    input  wire                       rst_reg_n,
    input  lora_soc_pkg::wb_req_t     i_wb,
    output lora_soc_pkg::wb_rsp_t     o_wb,
    output lora_soc_pkg::reg_wr_t     o_wr,
    input  lora_soc_pkg::reg_rd_t     i_rd,
    input  lora_soc_pkg::pin_in_t     i_pins
);

    logic                    ack_q;
    logic                    req;
    logic                    slot_hit;     // Peripheral space
    logic [`LORA_SLOT_W-1:0] slot;
    logic                    wr_fire;
    logic [`LORA_DATA_W-1:0] rd_word;

    assign req      = i_wb.cyc & i_wb.stb;
    assign slot     = i_wb.adr[6:2];
    assign slot_hit = ~i_wb.adr[7];

    // ====================
    // Ack, one wait state
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req & ~ack_q;         // Single-cycle pulse per request
        end
    end

    // Strobes land in the ack cycle, master still holds the request
    assign wr_fire = ack_q & req & i_wb.we & slot_hit;

    assign o_wr.gpio_out_we = wr_fire && (slot == `LORA_SLOT_GPIO_OUT);
    assign o_wr.gpio_sel_we = wr_fire && (slot == `LORA_SLOT_GPIO_SEL);
    assign o_wr.timer_we    = wr_fire && (slot == `LORA_SLOT_TIMER);
    assign o_wr.wdt_we      = wr_fire && (slot == `LORA_SLOT_WDT);
    assign o_wr.sysinfo_we  = wr_fire && (slot == `LORA_SLOT_SYSINFO);
    assign o_wr.dat         = i_wb.dat;

    // ====================
    // Read mux
    // ====================
    always_comb begin
        rd_word = `LORA_UNMAPPED_READ;   // Holes and upper space
        if (slot_hit) begin
            case (slot)
                // Register byte above, live pin state below
                `LORA_SLOT_GPIO_OUT: rd_word = {16'h0, i_rd.gpio_out, i_rd.pins};
                `LORA_SLOT_GPIO_IN:  rd_word = {24'h0, i_pins};
                `LORA_SLOT_GPIO_SEL: rd_word = {24'h0, i_rd.gpio_sel};
                `LORA_SLOT_TIMER:    rd_word = i_rd.timer_count;
                `LORA_SLOT_WDT:      rd_word = i_rd.wdt_remaining;
                `LORA_SLOT_SYSINFO:  rd_word = i_rd.sysinfo;
                default:             rd_word = `LORA_UNMAPPED_READ;
            endcase
        end
    end

    assign o_wb.ack = ack_q;
    assign o_wb.dat = rd_word;           // Valid while ack is high

    // Back-to-back acks would double a transfer
    a_ack_single: assert property (@(posedge clk) disable iff (!rst_reg_n)
        ack_q |=> !ack_q);

    // No register changes outside an acknowledged cycle
    a_wr_with_ack: assert property (@(posedge clk) disable iff (!rst_reg_n)
        (o_wr.gpio_out_we | o_wr.gpio_sel_we | o_wr.timer_we |
         o_wr.wdt_we | o_wr.sysinfo_we) |-> o_wb.ack);

endmodule

`default_nettype wire

// ==== hdl/us_tick_timer.sv ====
// Microsecond tick divider and 32-bit countdown timer with sticky expiry interrupt
`default_nettype none

`include "lora_soc_params.svh"

module us_tick_timer (
    input  wire                       clk,
    input  wire                       rst_reg_n,
    input  wire                       i_periph_rst_n,
    input  lora_soc_pkg::reg_wr_t     i_wr,
    output logic                      o_tick,
    output logic [`LORA_DATA_W-1:0]   o_timer_count,
    output logic                      o_timer_irq
);

    localparam int DIV_W = $clog2(`LORA_TICK_DIV);

    logic [DIV_W-1:0] div_cnt;

    // ====================
    // 1 us tick
    // ====================
    assign o_tick = (div_cnt == DIV_W'(`LORA_TICK_DIV - 1));

    always_ff @(posedge clk) begin
        if (!rst_reg_n || o_tick) begin
            div_cnt <= '0;                    // Wrap on tick
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ====================
    // Countdown timer
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_reg_n || !i_periph_rst_n) begin
            o_timer_count <= '0;
            o_timer_irq   <= 1'b0;
        end else if (i_wr.timer_we) begin
            o_timer_count <= i_wr.dat;        // Reload also acks the irq
            o_timer_irq   <= 1'b0;
        end else if (o_tick && o_timer_count != '0) begin
            o_timer_count <= o_timer_count - 1'b1;
            if (o_timer_count == `LORA_DATA_W'(1)) begin
                o_timer_irq <= 1'b1;          // Expired, held until reload
            end
        end
    end

    // Irq edge only once the count has run out
    a_irq_at_zero: assert property (@(posedge clk) disable iff (!rst_reg_n)
        $rose(o_timer_irq) |-> (o_timer_count == '0));

endmodule

`default_nettype wire

// ==== hdl/watchdog_reset.sv ====
// Watchdog, soft-reset key check and shared reset hold producing the peripheral reset
`default_nettype none

`include "lora_soc_params.svh"

module watchdog_reset (
    input  wire                       clk,
    input  wire                       rst_reg_n,
    input  wire                       i_tick,
    input  lora_soc_pkg::reg_wr_t     i_wr,
    output logic [`LORA_DATA_W-1:0]   o_wdt_remaining,
    output logic                      o_periph_rst_n
);

    localparam int HOLD_W = $clog2(`LORA_RST_HOLD + 1);

    logic              wdt_fire;
    logic              soft_rst;
    logic              rst_trigger;
    logic [HOLD_W-1:0] hold_cnt;

    // ====================
    // Watchdog counter
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_reg_n || !o_periph_rst_n) begin
            o_wdt_remaining <= '0;            // Idle until first kick
        end else if (i_wr.wdt_we) begin
            o_wdt_remaining <= i_wr.dat;      // Kick value in us
        end else if (i_tick && o_wdt_remaining != '0) begin
            o_wdt_remaining <= o_wdt_remaining - 1'b1;
        end
    end

    // Last tick from 1 to 0, unless a kick wins this cycle
    assign wdt_fire = i_tick && !i_wr.wdt_we && o_periph_rst_n &&
                      (o_wdt_remaining == `LORA_DATA_W'(1));

    // Software reset via key in sysinfo low byte
    assign soft_rst = i_wr.sysinfo_we && (i_wr.dat[7:0] == `LORA_SOFT_RST_KEY);

    assign rst_trigger = wdt_fire | soft_rst;

    // ====================
    // Reset hold
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            hold_cnt <= '0;
        end else if (rst_trigger) begin
            hold_cnt <= HOLD_W'(`LORA_RST_HOLD);  // Retrigger restarts the hold
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    // Registered so every block sees a clean sync reset
    always_ff @(posedge clk) begin
        if (!rst_reg_n) begin
            o_periph_rst_n <= 1'b0;
        end else begin
            o_periph_rst_n <= (hold_cnt == '0);
        end
    end

    // Full hold window seen by the peripherals after any trigger
    a_hold_len: assert property (@(posedge clk) disable iff (!rst_reg_n)
        rst_trigger |-> ##2 (!o_periph_rst_n) [*`LORA_RST_HOLD]);

endmodule

`default_nettype wire

// ==== hdl/gpio_pps_block.sv ====
// GPIO output and select registers, output pin mux and 1PPS edge counter
`default_nettype none

`include "lora_soc_params.svh"

module gpio_pps_block (
    input  wire                       clk,
    input  wire                       rst_reg_n,
    input  wire                       i_periph_rst_n,
    input  lora_soc_pkg::reg_wr_t     i_wr,
    input  lora_soc_pkg::pin_in_t     i_pins,
    output lora_soc_pkg::pin_out_t    o_pins,
    output logic [`LORA_PIN_W-1:0]    o_gpio_out,
    output logic [`LORA_PIN_W-1:0]    o_gpio_sel,
    output logic [`LORA_DATA_W-1:0]   o_sysinfo
);

    logic [1:0]             pps_sync;     // Async pin, two flops
    logic                   pps_prev;
    logic                   pps_rise;
    logic [`LORA_PPS_W-1:0] pps_count;

    // ====================
    // GPIO registers
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_reg_n || !i_periph_rst_n) begin
            o_gpio_out <= '0;
            o_gpio_sel <= '0;                 // All pins back on default
        end else begin
            if (i_wr.gpio_out_we) o_gpio_out <= i_wr.dat[`LORA_PIN_W-1:0];
            if (i_wr.gpio_sel_we) o_gpio_sel <= i_wr.dat[`LORA_PIN_W-1:0];
        end
    end

    // Per pin: GPIO bit if selected, else fixed default
    assign o_pins = lora_soc_pkg::pin_out_t'((o_gpio_sel & o_gpio_out) |
                                             (~o_gpio_sel & `LORA_GPIO_DEFAULT));

    // ====================
    // 1PPS counter
    // ====================
    always_ff @(posedge clk) begin
        pps_sync <= {pps_sync[0], i_pins.pps};
        pps_prev <= pps_sync[1];
    end

    assign pps_rise = pps_sync[1] & ~pps_prev;

    always_ff @(posedge clk) begin
        if (!rst_reg_n || !i_periph_rst_n) begin
            pps_count <= '0;
        end else if (pps_rise) begin
            pps_count <= pps_count + 1'b1;    // Wraps after 65535 s
        end
    end

    assign o_sysinfo = {pps_count, `LORA_CHIP_ID, `LORA_VERSION};

endmodule

`default_nettype wire

// ==== hdl/lora_periph_top.sv ====
// LoRa node peripheral subsystem top: bus decoder, timer, watchdog and GPIO/PPS
`default_nettype none

`include "lora_soc_params.svh"

module lora_periph_top (
    input  wire                       clk,
    input  wire                       rst_reg_n,
    input  lora_soc_pkg::wb_req_t     i_wb,
    output lora_soc_pkg::wb_rsp_t     o_wb,
    input  lora_soc_pkg::pin_in_t     i_pins,
    output lora_soc_pkg::pin_out_t    o_pins,
    output logic                      o_timer_irq
);

    lora_soc_pkg::reg_wr_t      wr;           // Strobes to all blocks
    wire lora_soc_pkg::reg_rd_t rd;           // Readback, one field per block
    logic                       tick;
    logic                       periph_rst_n;

    assign rd.pins = o_pins;

    periph_bus_decode u_decode (
        .clk        (clk),
        .rst_reg_n  (rst_reg_n),                // Bus stays up across soft reset
        .i_wb       (i_wb),
        .o_wb       (o_wb),
        .o_wr       (wr),
        .i_rd       (rd),
        .i_pins     (i_pins)
    );

    us_tick_timer u_timer (
        .clk            (clk),
        .rst_reg_n      (rst_reg_n),
        .i_periph_rst_n (periph_rst_n),
        .i_wr           (wr),
        .o_tick         (tick),
        .o_timer_count  (rd.timer_count),
        .o_timer_irq    (o_timer_irq)
    );

    watchdog_reset u_wdt (
        .clk             (clk),
        .rst_reg_n       (rst_reg_n),
        .i_tick          (tick),
        .i_wr            (wr),
        .o_wdt_remaining (rd.wdt_remaining),
        .o_periph_rst_n  (periph_rst_n)
    );

    gpio_pps_block u_gpio (
        .clk            (clk),
        .rst_reg_n      (rst_reg_n),
        .i_periph_rst_n (periph_rst_n),
        .i_wr           (wr),
        .i_pins         (i_pins),
        .o_pins         (o_pins),
        .o_gpio_out     (rd.gpio_out),
        .o_gpio_sel     (rd.gpio_sel),
        .o_sysinfo      (rd.sysinfo)
    );

endmodule

`default_nettype wire

// ==== dv/tb_lora_periph.sv ====
// Trace-driven testbench for the LoRa peripheral subsystem over Wishbone classic
`default_nettype none

module tb_lora_periph;

    localparam int MAX_OPS   = 128;
    localparam int CLK_HALF  = 10;          // 20 unit period
    localparam int ACK_LIMIT = 8;           // Cycles allowed for one bus ack
    localparam int OP_BUDGET = 300;         // Watchdog cycles per trace operation

    logic                   clk;
    logic                   rst_reg_n;
    lora_soc_pkg::wb_req_t  wb_req;
    lora_soc_pkg::wb_rsp_t  wb_rsp;
    lora_soc_pkg::pin_in_t  pins_in;
    lora_soc_pkg::pin_out_t pins_out;
    logic                   timer_irq;

    logic [31:0] trace_mem [0:4*MAX_OPS-1];  // Op, addr, data, expect per entry
    int          n_ops;
    logic        trace_ready;

    lora_periph_top u_dut (
        .clk         (clk),
        .rst_reg_n   (rst_reg_n),
        .i_wb        (wb_req),
        .o_wb        (wb_rsp),
        .i_pins      (pins_in),
        .o_pins      (pins_out),
        .o_timer_irq (timer_irq)
    );

    always #(CLK_HALF) clk = ~clk;

    // ====================
    // Checks
    // ====================
    task automatic stop_failed(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "Stopped on first error");
    endtask

    // Bounded mode for counts that may only go down
    task automatic check_rsp(input lora_soc_pkg::wb_rsp_t got, input lora_soc_pkg::wb_rsp_t exp,
                             input logic at_most, input string what);
        logic bad;
        bad = (got.ack !== exp.ack) || $isunknown(got.dat) ||
              (at_most ? (got.dat > exp.dat) : (got.dat !== exp.dat));
        if (bad) begin
            stop_failed($sformatf("MISMATCH at %0t: %s got ack %b dat %h, expected ack %b dat %s%h",
                $time, what, got.ack, got.dat, exp.ack, at_most ? "<= " : "", exp.dat));
        end
    endtask

    task automatic check_pins(input lora_soc_pkg::pin_out_t got,
                              input lora_soc_pkg::pin_out_t exp);
        if (got !== exp) begin
            stop_failed($sformatf("MISMATCH at %0t: output pins %h, expected %h", $time, got, exp));
        end
    endtask

    task automatic check_irq(input logic got, input logic exp);
        if (got !== exp) begin
            stop_failed($sformatf("MISMATCH at %0t: timer irq %b, expected %b", $time, got, exp));
        end
    endtask

    // ====================
    // Bus and wait helpers
    // ====================
    // Called on a falling edge and returns on the falling edge after the ack cycle
    task automatic bus_access(input logic we, input logic [7:0] adr, input logic [31:0] dat,
                              output lora_soc_pkg::wb_rsp_t rsp);
        int waited;
        waited = 0;
        if (wb_rsp.ack !== 1'b0) begin
            stop_failed($sformatf("MISMATCH at %0t: ack %b on an idle bus, expected 0",
                $time, wb_rsp.ack));
        end
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        do begin
            @(negedge clk);
            waited++;
            if (waited > ACK_LIMIT) begin
                stop_failed($sformatf("Bus access to 0x%02h got no ack in %0d cycles",
                    adr, ACK_LIMIT));
            end
        end while (wb_rsp.ack !== 1'b1);
        if (waited != 1) begin                  // One wait state
            stop_failed($sformatf("MISMATCH at %0t: ack to 0x%02h after %0d cycles, expected 1",
                $time, adr, waited));
        end
        rsp = wb_rsp;                       // Read data valid with ack
        @(negedge clk);                     // Request held across the strobe edge
        if (wb_rsp.ack !== 1'b0) begin          // Ack is a single-cycle pulse
            stop_failed($sformatf("MISMATCH at %0t: ack to 0x%02h held a second cycle",
                $time, adr));
        end
        wb_req = '0;
    endtask

    task automatic wait_irq(input int limit);
        int waited;
        waited = 0;
        while (timer_irq !== 1'b1) begin
            if (waited >= limit) begin
                stop_failed($sformatf("Timer interrupt did not rise within %0d cycles", limit));
            end
            @(negedge clk);
            waited++;
        end
    endtask

    // ====================
    // Trace player
    // ====================
    initial begin
        lora_soc_pkg::wb_rsp_t rsp;
        lora_soc_pkg::wb_rsp_t exp_rsp;
        logic [31:0]           op;
        logic [31:0]           adr;
        logic [31:0]           dat;
        logic [31:0]           expv;
        clk         = 1'b0;
        rst_reg_n   = 1'b0;
        wb_req      = '0;
        pins_in     = '0;
        trace_ready = 1'b0;
        n_ops       = 0;
        $readmemh("dv/lora_periph_trace.txt", trace_mem);
        while (n_ops < MAX_OPS && !$isunknown(trace_mem[4*n_ops]) &&
               trace_mem[4*n_ops] != 32'hF) begin
            n_ops++;
        end
        if (n_ops == 0) stop_failed("Trace file dv/lora_periph_trace.txt is empty or missing");
        trace_ready = 1'b1;
        repeat (3) @(posedge clk);          // Reset held 3 cycles
        @(negedge clk);
        rst_reg_n = 1'b1;
        repeat (2) @(negedge clk);          // Peripheral reset releases one cycle later
        for (int k = 0; k < n_ops; k++) begin
            op   = trace_mem[4*k];
            adr  = trace_mem[4*k+1];
            dat  = trace_mem[4*k+2];
            expv = trace_mem[4*k+3];
            case (op)
                32'h1: bus_access(1'b1, adr[7:0], dat, rsp);
                32'h2, 32'h8: begin
                    bus_access(1'b0, adr[7:0], 32'h0, rsp);
                    exp_rsp.ack = 1'b1;
                    exp_rsp.dat = expv;
                    check_rsp(rsp, exp_rsp, op == 32'h8, $sformatf("read of 0x%02h", adr[7:0]));
                end
                32'h3: begin
                    pins_in = lora_soc_pkg::pin_in_t'(dat[7:0]);
                    repeat (adr) @(negedge clk);  // Hold time in the addr column
                end
                32'h4: repeat (dat) @(negedge clk);
                32'h5: check_pins(pins_out, lora_soc_pkg::pin_out_t'(expv[7:0]));
                32'h6: check_irq(timer_irq, expv[0]);
                32'h7: wait_irq(dat);
                default: stop_failed($sformatf("Unknown trace op %0h in entry %0d", op, k));
            endcase
        end
        $display("Trace of %0d operations complete", n_ops);
        $display("Simulation PASSED");
        $finish;
    end

    // Run limit scales with trace length
    initial begin
        wait (trace_ready === 1'b1);
        repeat (n_ops * OP_BUDGET) @(posedge clk);
        stop_failed($sformatf("Timeout, %0d trace operations not done in %0d cycles",
            n_ops, n_ops * OP_BUDGET));
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+hdl
hdl/lora_soc_pkg.sv
hdl/periph_bus_decode.sv
hdl/us_tick_timer.sv
hdl/watchdog_reset.sv
hdl/gpio_pps_block.sv
hdl/lora_periph_top.sv
dv/tb_lora_periph.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the LoRa peripheral testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=tb_lora_periph

verilator --binary --timing --assert -f sim.f --top-module "$TOP" -Mdir "$BUILD_DIR"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG_FILE"; then
    exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1

// ==== dv/lora_periph_trace.txt ====
// Columns (hex): op addr data expect. Ops 1 write, 2 read, 3 set pins (addr = hold cycles),
// 4 idle data cycles, 5 check pins, 6 check irq, 7 wait irq up to data cycles, 8 read at most, f end
5 00 00000000 00000002
6 00 00000000 00000000
2 0C 00000000 00000000
// GPIO out 0xA5, select 0x0F
1 00 000000A5 00000000
1 0C 0000000F 00000000
5 00 00000000 00000005
2 00 00000000 0000A505
2 0C 00000000 0000000F
2 08 00000000 FFFFFFFF
2 80 00000000 FFFFFFFF
3 01 0000002B 00000000
2 04 00000000 0000002B
// Timer: expiry, then reload
1 30 00000003 00000000
6 00 00000000 00000000
7 00 00000064 00000000
1 30 00000003 00000000
6 00 00000000 00000000
8 30 00000000 00000003
4 00 0000001E 00000000
8 30 00000000 00000002
// Watchdog kick of 2
1 34 00000002 00000000
4 00 00000064 00000000
2 0C 00000000 00000000
5 00 00000000 00000002
2 34 00000000 00000000
6 00 00000000 00000000
// Two PPS pulses
3 05 00000010 00000000
3 05 00000000 00000000
3 05 00000010 00000000
3 05 00000000 00000000
2 3C 00000000 00020110
// Soft reset: wrong key, then key
1 00 0000003C 00000000
1 0C 000000FF 00000000
1 3C 0000005A 00000000
4 00 00000028 00000000
2 00 00000000 00003C3C
5 00 00000000 0000003C
1 3C 000000A5 00000000
4 00 00000028 00000000
2 0C 00000000 00000000
5 00 00000000 00000002
2 3C 00000000 00000110
f 00 00000000 00000000
